/* filelist.f */
verilog/conv_pkg.sv
verilog/line_mem_if.sv
verilog/conv_sequencer.sv
verilog/line_mem_bank.sv
verilog/mux_array.sv
verilog/conv_window_unit.sv
verilog/result_drain.sv
verilog/conv_array_top.sv
test/conv_array_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the convolution engine testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module conv_array_tb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vconv_array_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "PASS: all tests"; then
    exit 0
fi
exit 1

/* test/conv_array_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_array_tb;
    localparam int N           = 4;
    localparam int IMG_W       = 16;
    localparam int BANDS       = 3;
    localparam int BITS_IMAGEN = 8;
    localparam int BITS_COEF   = 4;
    localparam int BITS_DATA   = 16;
    localparam int IMG_H       = N*BANDS + 2;
    localparam int OUT_W       = IMG_W - 2;
    localparam int FRAMES      = 2;
    // Load, sweep and drain cycles of one frame.
    localparam int FRAME_CYC   = IMG_H*IMG_W + BANDS*(IMG_W + 4) + BANDS*N*OUT_W;
    localparam longint WATCH_NS = 2*FRAMES*FRAME_CYC*40 + 200*40;

    logic                                       i_clk = 1'b0;
    logic                                       i_arst_n;
    logic [conv_pkg::KERNEL_TAPS*BITS_COEF-1:0] i_kernel;
    logic [BITS_IMAGEN-1:0]                     i_pix;
    logic                                       i_pix_valid;
    logic                                       o_load_ready;
    logic [BITS_DATA-1:0]                       o_res;
    logic                                       o_res_valid;
    logic                                       o_frame_done;

    integer seed = 77;
    int     kern [conv_pkg::KERNEL_TAPS];
    int     img [IMG_H*IMG_W];
    int     ptr;
    int     res_count = 0;
    int     done_count = 0;
    logic signed [BITS_DATA-1:0] exp_q [$];

    conv_array_top #(
        .N(N), .IMG_W(IMG_W), .BANDS(BANDS), .BITS_IMAGEN(BITS_IMAGEN),
        .BITS_COEF(BITS_COEF), .BITS_DATA(BITS_DATA)
    ) uut (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_kernel     (i_kernel),
        .i_pix        (i_pix),
        .i_pix_valid  (i_pix_valid),
        .o_load_ready (o_load_ready),
        .o_res        (o_res),
        .o_res_valid  (o_res_valid),
        .o_frame_done (o_frame_done)
    );

    always #20 i_clk = ~i_clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_res(input logic signed [BITS_DATA-1:0] got,
                             input logic signed [BITS_DATA-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail o_res: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    // New kernel and image with expected results queued band by band.
    task automatic make_frame();
        int sum;
        int r;
        for (int t = 0; t < conv_pkg::KERNEL_TAPS; t++) begin
            kern[t] = ($random(seed) & 15) - 8;
            i_kernel[t*BITS_COEF +: BITS_COEF] = BITS_COEF'(kern[t]);
        end
        for (int p = 0; p < IMG_H*IMG_W; p++) begin
            img[p] = $random(seed) & 255;
        end
        for (int b = 0; b < BANDS; b++) begin
            for (int i = 0; i < N; i++) begin
                r = N*b + i;
                for (int c = 0; c < OUT_W; c++) begin
                    sum = 0;
                    for (int dr = 0; dr < 3; dr++) begin
                        for (int dc = 0; dc < 3; dc++) begin
                            sum += kern[3*dr + dc] * img[(r + dr)*IMG_W + c + dc];
                        end
                    end
                    exp_q.push_back(BITS_DATA'(sum));
                end
            end
        end
    endtask

    task automatic wait_load_ready();
        while (!o_load_ready) begin
            @(posedge i_clk);
            #2;
        end
    endtask

    // Random idle gaps between pixels.
    task automatic feed_band(input int need);
        int taken;
        taken = 0;
        while (taken < need) begin
            check_level("o_load_ready", o_load_ready, 1'b1);
            if (($random(seed) & 3) == 0) begin
                i_pix_valid = 1'b0;
            end else begin
                i_pix_valid = 1'b1;
                i_pix       = BITS_IMAGEN'(img[ptr]);
                ptr++;
                taken++;
            end
            @(posedge i_clk);
            #2;
        end
        i_pix_valid = 1'b0;
        check_level("o_load_ready", o_load_ready, 1'b0);  // Band complete.
    endtask

    always @(negedge i_clk) begin : monitor
        logic signed [BITS_DATA-1:0] want;
        if (i_arst_n) begin
            if (o_res_valid) begin
                if (o_load_ready) begin
                    abort_run("Result valid while the design was still loading pixels.");
                end
                if (exp_q.size() == 0) begin
                    abort_run("Result appeared with no expected value left.");
                end
                want = exp_q.pop_front();
                check_res(o_res, want);
                res_count++;
            end
            if (o_frame_done) begin
                if (exp_q.size() != 0) begin
                    abort_run("Frame done pulsed before all results were out.");
                end
                done_count++;
            end
        end
    end

    initial begin : watchdog
        #(WATCH_NS);
        abort_run("Timeout: the run took longer than the expected frame time.");
    end

    initial begin : stimulus
        int band_start;
        i_arst_n    = 1'b0;
        i_kernel    = '0;
        i_pix       = '0;
        i_pix_valid = 1'b0;
        repeat (10) @(posedge i_clk);
        #2;
        i_arst_n = 1'b1;
        check_level("o_load_ready", o_load_ready, 1'b1);
        check_level("o_res_valid", o_res_valid, 1'b0);
        check_level("o_frame_done", o_frame_done, 1'b0);

        for (int f = 0; f < FRAMES; f++) begin
            make_frame();
            ptr = 0;
            for (int b = 0; b < BANDS; b++) begin
                wait_load_ready();
                band_start = res_count;
                feed_band((b == 0) ? (N + 2)*IMG_W : N*IMG_W);
                wait_load_ready();
                check_count("results per band", res_count - band_start, N*OUT_W);
            end
            @(posedge i_clk);
            #2;
            check_count("o_frame_done pulses", done_count, f + 1);
        end

        repeat (4) @(posedge i_clk);
        #2;
        check_count("o_frame_done pulses", done_count, FRAMES);
        if (exp_q.size() != 0) begin
            abort_run("Expected results were left over at the end.");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verilog/conv_array_top.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_array_top #(
    parameter int N           = 4,
    parameter int IMG_W       = 16,
    parameter int BANDS       = 3,
    parameter int BITS_IMAGEN = 8,
    parameter int BITS_COEF   = 4,
    parameter int BITS_DATA   = 16
) (
    input  wire                                       i_clk,
    input  wire                                       i_arst_n,
    input  wire [conv_pkg::KERNEL_TAPS*BITS_COEF-1:0] i_kernel,
    input  wire [BITS_IMAGEN-1:0]                     i_pix,
    input  wire                                       i_pix_valid,
    output logic                                      o_load_ready,
    output logic [BITS_DATA-1:0]                      o_res,
    output logic                                      o_res_valid,
    output logic                                      o_frame_done
);
    localparam int SUB_W    = $clog2(N/2 + 1);
    localparam int TRIPLE_W = conv_pkg::WINDOW_ROWS * BITS_IMAGEN;

    logic [SUB_W-1:0]      substate;
    logic                  col_valid;
    logic                  start_drain;
    logic                  drain_done;
    logic [N*TRIPLE_W-1:0] windows;
    logic [N*BITS_DATA-1:0] res;
    logic                  res_valid;

    line_mem_if #(.N(N), .IMG_W(IMG_W), .BITS_IMAGEN(BITS_IMAGEN)) mem_bus ();

    conv_sequencer #(.N(N), .IMG_W(IMG_W), .BANDS(BANDS), .BITS_IMAGEN(BITS_IMAGEN)) u_seq (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_pix         (i_pix),
        .i_pix_valid   (i_pix_valid),
        .o_load_ready  (o_load_ready),
        .bus           (mem_bus.writer),
        .o_substate    (substate),
        .o_col_valid   (col_valid),
        .o_start_drain (start_drain),
        .i_drain_done  (drain_done),
        .o_frame_done  (o_frame_done)
    );

    line_mem_bank #(.N(N), .IMG_W(IMG_W), .BITS_IMAGEN(BITS_IMAGEN)) u_bank (
        .i_clk (i_clk),
        .bus   (mem_bus.mem)
    );

    mux_array #(.N(N), .BITS_IMAGEN(BITS_IMAGEN)) u_mux (
        .bus        (mem_bus.reader),
        .i_substate (substate),
        .o_windows  (windows)
    );

    // All lanes run in lockstep, lane 0 supplies the strobe.
    for (genvar i = 0; i < N; i++) begin : g_lane
        if (i == 0) begin : g_lead
            conv_window_unit #(
                .BITS_IMAGEN(BITS_IMAGEN), .BITS_COEF(BITS_COEF), .BITS_DATA(BITS_DATA)
            ) u_conv (
                .i_clk       (i_clk),
                .i_arst_n    (i_arst_n),
                .i_kernel    (i_kernel),
                .i_column    (windows[i*TRIPLE_W +: TRIPLE_W]),
                .i_col_valid (col_valid),
                .o_res       (res[i*BITS_DATA +: BITS_DATA]),
                .o_res_valid (res_valid)
            );
        end else begin : g_follow
            conv_window_unit #(
                .BITS_IMAGEN(BITS_IMAGEN), .BITS_COEF(BITS_COEF), .BITS_DATA(BITS_DATA)
            ) u_conv (
                .i_clk       (i_clk),
                .i_arst_n    (i_arst_n),
                .i_kernel    (i_kernel),
                .i_column    (windows[i*TRIPLE_W +: TRIPLE_W]),
                .i_col_valid (col_valid),
                .o_res       (res[i*BITS_DATA +: BITS_DATA]),
                .o_res_valid ()
            );
        end
    end

    result_drain #(.N(N), .IMG_W(IMG_W), .BITS_DATA(BITS_DATA)) u_drain (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_res         (res),
        .i_res_valid   (res_valid),
        .i_start_drain (start_drain),
        .o_res         (o_res),
        .o_res_valid   (o_res_valid),
        .o_drain_done  (drain_done)
    );

endmodule

`default_nettype wire

/* verilog/conv_pkg.sv */
`default_nettype none

package conv_pkg;

    // Controller phases of one band.
    typedef enum logic [1:0] {
        ST_LOAD  = 2'd0,
        ST_CONV  = 2'd1,
        ST_DRAIN = 2'd2
    } conv_state_e;

    localparam int KERNEL_TAPS = 9;  // 3x3 coefficients.
    localparam int WINDOW_ROWS = 3;

endpackage

`default_nettype wire

/* verilog/conv_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_sequencer #(
    parameter int N           = 4,
    parameter int IMG_W       = 16,
    parameter int BANDS       = 3,
    parameter int BITS_IMAGEN = 8
) (
    input  wire                           i_clk,
    input  wire                           i_arst_n,
    input  wire [BITS_IMAGEN-1:0]         i_pix,
    input  wire                           i_pix_valid,
    output logic                          o_load_ready,
    line_mem_if.writer                    bus,
    output logic [$clog2(N/2+1)-1:0]      o_substate,
    output logic                          o_col_valid,
    output logic                          o_start_drain,
    input  wire                           i_drain_done,
    output logic                          o_frame_done
);
    localparam int SUB    = N/2 + 1;
    localparam int SUB_W  = $clog2(SUB);
    localparam int MEMS   = N + 2;
    localparam int MEM_W  = $clog2(MEMS);
    localparam int ROW_W  = $clog2(N + 3);
    localparam int COL_W  = $clog2(IMG_W);
    localparam int CNT_W  = $clog2(IMG_W + 3);
    localparam int BAND_W = (BANDS > 1) ? $clog2(BANDS) : 1;

    conv_pkg::conv_state_e state;
    logic [COL_W-1:0]      col;
    logic [MEM_W-1:0]      mem_sel;    // Image row mod (N+2).
    logic [ROW_W-1:0]      rows_done;
    logic [ROW_W-1:0]      rows_needed;
    logic [CNT_W-1:0]      conv_cnt;
    logic [BAND_W-1:0]     band;
    logic                  pix_take;
    logic                  row_end;
    logic                  load_end;
    logic                  last_band;

    assign pix_take    = i_pix_valid && (state == conv_pkg::ST_LOAD);
    assign row_end     = (col == COL_W'(IMG_W - 1));
    assign rows_needed = (band == '0) ? ROW_W'(N + conv_pkg::WINDOW_ROWS - 1) : ROW_W'(N);
    assign load_end    = pix_take && row_end && (rows_done == rows_needed - 1'b1);
    assign last_band   = (band == BAND_W'(BANDS - 1));

    assign o_load_ready  = (state == conv_pkg::ST_LOAD);
    // Read latency plus result register after the last column.
    assign o_start_drain = (state == conv_pkg::ST_CONV) && (conv_cnt == CNT_W'(IMG_W + 2));

    assign bus.we    = pix_take ? (MEMS'(1) << mem_sel) : '0;
    assign bus.waddr = col;
    assign bus.wdata = i_pix;
    assign bus.raddr = conv_cnt[COL_W-1:0];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state        <= conv_pkg::ST_LOAD;
            col          <= '0;
            mem_sel      <= '0;
            rows_done    <= '0;
            conv_cnt     <= '0;
            band         <= '0;
            o_substate   <= '0;
            o_col_valid  <= 1'b0;
            o_frame_done <= 1'b0;
        end else begin
            o_col_valid  <= (state == conv_pkg::ST_CONV) && (conv_cnt < CNT_W'(IMG_W));
            o_frame_done <= 1'b0;
            case (state)
                conv_pkg::ST_LOAD: begin
                    if (pix_take) begin
                        col <= row_end ? '0 : col + 1'b1;
                        if (row_end) begin
                            mem_sel   <= (mem_sel == MEM_W'(N + 1)) ? '0 : mem_sel + 1'b1;
                            rows_done <= rows_done + 1'b1;
                        end
                        if (load_end) begin
                            rows_done <= '0;
                            conv_cnt  <= '0;
                            state     <= conv_pkg::ST_CONV;
                        end
                    end
                end
                conv_pkg::ST_CONV: begin
                    conv_cnt <= conv_cnt + 1'b1;
                    if (o_start_drain) begin
                        state <= conv_pkg::ST_DRAIN;
                    end
                end
                conv_pkg::ST_DRAIN: begin
                    if (i_drain_done) begin
                        state <= conv_pkg::ST_LOAD;
                        if (last_band) begin
                            // New frame starts at memory 0.
                            band         <= '0;
                            o_substate   <= '0;
                            mem_sel      <= '0;
                            o_frame_done <= 1'b1;
                        end else begin
                            band       <= band + 1'b1;
                            o_substate <= (o_substate == SUB_W'(SUB - 1)) ? '0 : o_substate + 1'b1;
                        end
                    end
                end
                default: state <= conv_pkg::ST_LOAD;
            endcase
        end
    end

    a_pix_in_load: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_pix_valid |-> state == conv_pkg::ST_LOAD)
        else $error("Pixel offered while not loading.");

endmodule

`default_nettype wire

/* verilog/conv_window_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_window_unit #(
    parameter int BITS_IMAGEN = 8,
    parameter int BITS_COEF   = 4,
    parameter int BITS_DATA   = 16
) (
    input  wire                                           i_clk,
    input  wire                                           i_arst_n,
    input  wire [conv_pkg::KERNEL_TAPS*BITS_COEF-1:0]     i_kernel,
    input  wire [conv_pkg::WINDOW_ROWS*BITS_IMAGEN-1:0]   i_column,
    input  wire                                           i_col_valid,
    output logic [BITS_DATA-1:0]                          o_res,
    output logic                                          o_res_valid
);
    localparam int ROWS   = conv_pkg::WINDOW_ROWS;
    localparam int COL_W  = ROWS * BITS_IMAGEN;
    localparam int HIST_W = (ROWS - 1) * COL_W;
    localparam int CNT_W  = $clog2(ROWS);

    logic [HIST_W-1:0]           hist;     // Oldest column in the low bits.
    logic [ROWS*COL_W-1:0]       win;
    logic [CNT_W-1:0]            col_cnt;
    logic                        full;
    logic signed [BITS_DATA-1:0] acc;

    assign win  = {i_column, hist};
    assign full = (col_cnt == CNT_W'(ROWS - 1));

    always_comb begin
        logic signed [BITS_COEF-1:0] coef;
        logic signed [BITS_IMAGEN:0] pix;
        acc = '0;
        for (int dr = 0; dr < ROWS; dr++) begin
            for (int dc = 0; dc < ROWS; dc++) begin
                coef = i_kernel[(dr*ROWS + dc)*BITS_COEF +: BITS_COEF];
                pix  = {1'b0, win[dc*COL_W + dr*BITS_IMAGEN +: BITS_IMAGEN]};
                acc  = acc + coef * pix;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            col_cnt     <= '0;
            o_res_valid <= 1'b0;
        end else begin
            o_res_valid <= i_col_valid && full;
            if (!i_col_valid) begin
                col_cnt <= '0;  // Row sweep over.
            end else if (!full) begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_col_valid) begin
            hist <= {i_column, hist[HIST_W-1:COL_W]};
            if (full) begin
                o_res <= acc;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/line_mem_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module line_mem_bank #(
    parameter int N           = 4,
    parameter int IMG_W       = 16,
    parameter int BITS_IMAGEN = 8
) (
    input  wire         i_clk,
    line_mem_if.mem     bus
);

    for (genvar m = 0; m < N + 2; m++) begin : g_line
        logic [BITS_IMAGEN-1:0] cells [IMG_W];
        logic [BITS_IMAGEN-1:0] rd_q;

        always_ff @(posedge i_clk) begin
            if (bus.we[m]) begin
                cells[bus.waddr] <= bus.wdata;
            end
            rd_q <= cells[bus.raddr];  // Shared address, one cycle.
        end

        assign bus.rdata[m*BITS_IMAGEN +: BITS_IMAGEN] = rd_q;
    end

    // A pixel lands in exactly one ring slot.
    a_one_write: assert property (@(posedge i_clk) $onehot0(bus.we))
        else $error("More than one line memory written.");

endmodule

`default_nettype wire

/* verilog/line_mem_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface line_mem_if #(
    parameter int N           = 4,
    parameter int IMG_W       = 16,
    parameter int BITS_IMAGEN = 8
);
    localparam int ADDR_W = $clog2(IMG_W);

    logic [N+1:0]                 we;     // One enable per line memory.
    logic [ADDR_W-1:0]            waddr;
    logic [BITS_IMAGEN-1:0]       wdata;
    logic [ADDR_W-1:0]            raddr;
    logic [(N+2)*BITS_IMAGEN-1:0] rdata;  // Memory m in slice m.

    modport writer (output we, output waddr, output wdata, output raddr);
    modport mem    (input we, input waddr, input wdata, input raddr, output rdata);
    modport reader (input rdata);

endinterface

`default_nettype wire

/* verilog/mux_array.sv */
`timescale 1ns/100ps
`default_nettype none

module mux_array #(
    parameter int N           = 4,
    parameter int BITS_IMAGEN = 8
) (
    line_mem_if.reader                                    bus,
    input  wire [$clog2(N/2+1)-1:0]                       i_substate,
    output logic [N*conv_pkg::WINDOW_ROWS*BITS_IMAGEN-1:0] o_windows
);
    localparam int SUB      = N/2 + 1;
    localparam int ROWS     = conv_pkg::WINDOW_ROWS;
    localparam int TRIPLE_W = ROWS * BITS_IMAGEN;

    for (genvar i = 0; i < N; i++) begin : g_conv
        logic [TRIPLE_W-1:0] cand [SUB];

        // Sub-state j places band rows on memories N*j+i onward.
        for (genvar j = 0; j < SUB; j++) begin : g_sub
            for (genvar k = 0; k < ROWS; k++) begin : g_row
                assign cand[j][k*BITS_IMAGEN +: BITS_IMAGEN] =
                    bus.rdata[((N*j + i + k) % (N + 2))*BITS_IMAGEN +: BITS_IMAGEN];
            end
        end

        assign o_windows[i*TRIPLE_W +: TRIPLE_W] = cand[i_substate];
    end

    always_comb begin
        a_sub_range: assert (i_substate < SUB)
            else $error("Sub-state beyond ring rotation.");
    end

endmodule

`default_nettype wire

/* verilog/result_drain.sv */
`timescale 1ns/100ps
`default_nettype none

module result_drain #(
    parameter int N         = 4,
    parameter int IMG_W     = 16,
    parameter int BITS_DATA = 16
) (
    input  wire                   i_clk,
    input  wire                   i_arst_n,
    input  wire [N*BITS_DATA-1:0] i_res,
    input  wire                   i_res_valid,
    input  wire                   i_start_drain,
    output logic [BITS_DATA-1:0]  o_res,
    output logic                  o_res_valid,
    output logic                  o_drain_done
);
    localparam int OUT_W = IMG_W - conv_pkg::WINDOW_ROWS + 1;
    localparam int COL_W = $clog2(OUT_W);
    localparam int ROW_W = (N > 1) ? $clog2(N) : 1;

    logic [BITS_DATA-1:0]  rbuf [N][OUT_W];
    logic [COL_W-1:0]      wr_col;
    logic [COL_W-1:0]      rd_col;
    logic [ROW_W-1:0]      rd_row;
    logic                  rd_last;
    conv_pkg::conv_state_e phase;  // ST_CONV collects, ST_DRAIN reads.

    assign rd_last = (rd_row == ROW_W'(N - 1)) && (rd_col == COL_W'(OUT_W - 1));

    always_ff @(posedge i_clk) begin
        if (i_res_valid) begin
            for (int i = 0; i < N; i++) begin
                rbuf[i][wr_col] <= i_res[i*BITS_DATA +: BITS_DATA];
            end
        end
        if (phase == conv_pkg::ST_DRAIN) begin
            o_res <= rbuf[rd_row][rd_col];
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            phase        <= conv_pkg::ST_CONV;
            wr_col       <= '0;
            rd_col       <= '0;
            rd_row       <= '0;
            o_res_valid  <= 1'b0;
            o_drain_done <= 1'b0;
        end else begin
            o_res_valid  <= (phase == conv_pkg::ST_DRAIN);
            o_drain_done <= (phase == conv_pkg::ST_DRAIN) && rd_last;
            if (i_res_valid) begin
                wr_col <= (wr_col == COL_W'(OUT_W - 1)) ? '0 : wr_col + 1'b1;
            end
            if (i_start_drain) begin
                phase  <= conv_pkg::ST_DRAIN;
                rd_row <= '0;
                rd_col <= '0;
            end else if (phase == conv_pkg::ST_DRAIN) begin
                if (rd_col == COL_W'(OUT_W - 1)) begin
                    rd_col <= '0;
                    rd_row <= rd_row + 1'b1;  // Next band row.
                end else begin
                    rd_col <= rd_col + 1'b1;
                end
                if (rd_last) begin
                    phase <= conv_pkg::ST_CONV;
                end
            end
        end
    end

    a_no_restart: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_start_drain |-> phase != conv_pkg::ST_DRAIN)
        else $error("Drain restarted before finishing.");

    // Convolvers must be idle while the buffer is read out.
    a_quiet_in_drain: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_res_valid |-> phase != conv_pkg::ST_DRAIN)
        else $error("Result arrived during drain.");

endmodule

`default_nettype wire
